//--- all.f
+incdir+source
source/icb_pkg.sv
source/dtcm_pkg.sv
source/icb_if.sv
source/cpu_reset_ctrl.sv
source/cpu_irq_sync.sv
source/dtcm_icb_arbiter.sv
source/dtcm_sram_ctrl.sv
source/cpu_top.sv
tb/cpu_top_asserts.sv
tb/tb_cpu_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_cpu_top -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  && ! grep -q "Result: FAILED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- source/cpu_irq_sync.sv
// Interrupt synchronizer
// Brings the four asynchronous interrupt lines into the clk domain

`timescale 1ns/100ps

`include "cpu_params.svh"

module cpu_irq_sync (
  input  logic clk,
  input  logic reset,
  input  logic dbg_irq_a,
  input  logic ext_irq_a,
  input  logic sft_irq_a,
  input  logic tmr_irq_a,
  output logic dbg_irq_r,
  output logic ext_irq_r,
  output logic sft_irq_r,
  output logic tmr_irq_r
);

  localparam int NUM_IRQ = 4;

  logic [NUM_IRQ-1:0]                       irq_a;
  logic [`IRQ_SYNC_STAGES-1:0][NUM_IRQ-1:0] sync_chain;

  assign irq_a = {dbg_irq_a, ext_irq_a, sft_irq_a, tmr_irq_a};

  // All four lines shift through the same chain, one flop per stage
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_chain <= '0;
    end else begin
      sync_chain[0] <= irq_a;
      for (int i = 1; i < `IRQ_SYNC_STAGES; i++) begin
        sync_chain[i] <= sync_chain[i-1];
      end
    end
  end

  assign {dbg_irq_r, ext_irq_r, sft_irq_r, tmr_irq_r} = sync_chain[`IRQ_SYNC_STAGES-1];

endmodule

//--- source/cpu_params.svh
// Core integration parameters
// Word width, DTCM geometry, reset stretch and IRQ synchronizer depth

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

//////////////////////////////////////////////////
// Data path

`define CPU_XLEN 32

//////////////////////////////////////////////////
// DTCM geometry

// Byte address seen on the ICB ports
`define DTCM_ADDR_WIDTH 16
// Word address into the SRAM macro
`define DTCM_RAM_AW 14

//////////////////////////////////////////////////
// Reset and interrupt timing

// Extra cycles the memory domain stays in reset
`define DTCM_RST_CYCLES 4
`define IRQ_SYNC_STAGES 2

`endif

//--- source/cpu_reset_ctrl.sv
// Reset sequencer
// Stretches the DTCM reset past the release of the chip reset

`timescale 1ns/100ps

`include "cpu_params.svh"

module cpu_reset_ctrl (
  input  logic clk,
  input  logic reset,
  output logic dtcm_reset
);

  localparam int CNT_W = $clog2(`DTCM_RST_CYCLES + 1);

  logic [CNT_W-1:0] hold_cnt;

  // Counter reloads while reset is asserted, then counts down to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_cnt <= CNT_W'(`DTCM_RST_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // Registered so the memory domain sees a clean reset edge
  // Drops in the cycle after the count reaches one
  always_ff @(posedge clk) begin
    if (reset) begin
      dtcm_reset <= 1'b1;
    end else begin
      dtcm_reset <= hold_cnt > CNT_W'(1);
    end
  end

endmodule

//--- source/cpu_top.sv
// CPU integration top
// Reset sequencing, interrupt sync and the DTCM path out to an external SRAM

`timescale 1ns/100ps

module cpu_top (
  input  logic               clk,
  input  logic               reset,
  // Interrupts
  input  logic               dbg_irq_a,
  input  logic               ext_irq_a,
  input  logic               sft_irq_a,
  input  logic               tmr_irq_a,
  output logic               dbg_irq_r,
  output logic               ext_irq_r,
  output logic               sft_irq_r,
  output logic               tmr_irq_r,
  // LSU to DTCM
  input  logic               lsu_cmd_valid,
  output logic               lsu_cmd_ready,
  input  icb_pkg::icb_addr_t lsu_cmd_addr,
  input  logic               lsu_cmd_read,
  input  icb_pkg::icb_data_t lsu_cmd_wdata,
  input  icb_pkg::icb_mask_t lsu_cmd_wmask,
  output logic               lsu_rsp_valid,
  input  logic               lsu_rsp_ready,
  output logic               lsu_rsp_err,
  output icb_pkg::icb_data_t lsu_rsp_rdata,
  // External agent to DTCM
  input  logic               ext_cmd_valid,
  output logic               ext_cmd_ready,
  input  icb_pkg::icb_addr_t ext_cmd_addr,
  input  logic               ext_cmd_read,
  input  icb_pkg::icb_data_t ext_cmd_wdata,
  input  icb_pkg::icb_mask_t ext_cmd_wmask,
  output logic               ext_rsp_valid,
  input  logic               ext_rsp_ready,
  output logic               ext_rsp_err,
  output icb_pkg::icb_data_t ext_rsp_rdata,
  // DTCM SRAM
  output logic               ram_cs,
  output logic               ram_we,
  output icb_pkg::ram_addr_t ram_addr,
  output icb_pkg::icb_mask_t ram_wem,
  output icb_pkg::icb_data_t ram_din,
  input  icb_pkg::icb_data_t ram_dout
);
  import icb_pkg::*;

  logic dtcm_reset;

  icb_if lsu_icb ();
  icb_if ext_icb ();
  icb_if mem_icb ();

  cpu_reset_ctrl u_reset_ctrl (
    .clk        (clk),
    .reset      (reset),
    .dtcm_reset (dtcm_reset)
  );

  cpu_irq_sync u_irq_sync (
    .clk       (clk),
    .reset     (reset),
    .dbg_irq_a (dbg_irq_a),
    .ext_irq_a (ext_irq_a),
    .sft_irq_a (sft_irq_a),
    .tmr_irq_a (tmr_irq_a),
    .dbg_irq_r (dbg_irq_r),
    .ext_irq_r (ext_irq_r),
    .sft_irq_r (sft_irq_r),
    .tmr_irq_r (tmr_irq_r)
  );

  //////////////////////////////////////////////////
  // Plain ports onto the ICB links

  assign lsu_icb.cmd_valid = lsu_cmd_valid;
  assign lsu_icb.cmd_addr  = lsu_cmd_addr;
  assign lsu_icb.cmd_kind  = lsu_cmd_read ? ICB_READ : ICB_WRITE;
  assign lsu_icb.cmd_wdata = lsu_cmd_wdata;
  assign lsu_icb.cmd_wmask = lsu_cmd_wmask;
  assign lsu_icb.rsp_ready = lsu_rsp_ready;
  assign lsu_cmd_ready     = lsu_icb.cmd_ready;
  assign lsu_rsp_valid     = lsu_icb.rsp_valid;
  assign lsu_rsp_err       = lsu_icb.rsp_err;
  assign lsu_rsp_rdata     = lsu_icb.rsp_rdata;

  assign ext_icb.cmd_valid = ext_cmd_valid;
  assign ext_icb.cmd_addr  = ext_cmd_addr;
  assign ext_icb.cmd_kind  = ext_cmd_read ? ICB_READ : ICB_WRITE;
  assign ext_icb.cmd_wdata = ext_cmd_wdata;
  assign ext_icb.cmd_wmask = ext_cmd_wmask;
  assign ext_icb.rsp_ready = ext_rsp_ready;
  assign ext_cmd_ready     = ext_icb.cmd_ready;
  assign ext_rsp_valid     = ext_icb.rsp_valid;
  assign ext_rsp_err       = ext_icb.rsp_err;
  assign ext_rsp_rdata     = ext_icb.rsp_rdata;

  //////////////////////////////////////////////////
  // DTCM, held in reset longer than the rest

  dtcm_icb_arbiter u_dtcm_arbiter (
    .clk   (clk),
    .reset (dtcm_reset),
    .lsu   (lsu_icb.slave),
    .ext   (ext_icb.slave),
    .mem   (mem_icb.master)
  );

  dtcm_sram_ctrl u_dtcm_sram_ctrl (
    .clk      (clk),
    .reset    (dtcm_reset),
    .icb      (mem_icb.slave),
    .ram_cs   (ram_cs),
    .ram_we   (ram_we),
    .ram_addr (ram_addr),
    .ram_wem  (ram_wem),
    .ram_din  (ram_din),
    .ram_dout (ram_dout)
  );

endmodule

//--- source/dtcm_icb_arbiter.sv
// DTCM port arbiter
// Fixed priority between the external agent and the LSU, one command in flight

`timescale 1ns/100ps

module dtcm_icb_arbiter (
  input  logic  clk,
  input  logic  reset,
  icb_if.slave  lsu,
  icb_if.slave  ext,
  icb_if.master mem
);
  import dtcm_pkg::*;

  rsp_owner_e owner;
  logic       arb_free;
  logic       sel_ext;
  logic       mem_cmd_fire;
  logic       mem_rsp_fire;

  //////////////////////////////////////////////////
  // Command path

  // No new grant while a response is still owed to someone
  assign arb_free = owner == OWN_NONE;

  // External agent wins a tie
  assign sel_ext = ext.cmd_valid;

  assign mem.cmd_valid = arb_free & (ext.cmd_valid | lsu.cmd_valid);
  assign mem.cmd_addr  = sel_ext ? ext.cmd_addr : lsu.cmd_addr;
  assign mem.cmd_kind  = sel_ext ? ext.cmd_kind : lsu.cmd_kind;
  assign mem.cmd_wdata = sel_ext ? ext.cmd_wdata : lsu.cmd_wdata;
  assign mem.cmd_wmask = sel_ext ? ext.cmd_wmask : lsu.cmd_wmask;

  // Ready passes straight through from the SRAM side
  assign ext.cmd_ready = arb_free & mem.cmd_ready;
  assign lsu.cmd_ready = arb_free & ~ext.cmd_valid & mem.cmd_ready;

  assign mem_cmd_fire = mem.cmd_valid & mem.cmd_ready;
  assign mem_rsp_fire = mem.rsp_valid & mem.rsp_ready;

  //////////////////////////////////////////////////
  // Response ownership

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= OWN_NONE;
    end else if (mem_cmd_fire) begin
      owner <= sel_ext ? OWN_EXT : OWN_LSU;
    end else if (mem_rsp_fire) begin
      owner <= OWN_NONE;
    end
  end

  //////////////////////////////////////////////////
  // Response path

  assign lsu.rsp_valid = mem.rsp_valid & (owner == OWN_LSU);
  assign ext.rsp_valid = mem.rsp_valid & (owner == OWN_EXT);

  // Payload goes to both, valid tells each port whether it is theirs
  assign lsu.rsp_err   = mem.rsp_err;
  assign lsu.rsp_rdata = mem.rsp_rdata;
  assign ext.rsp_err   = mem.rsp_err;
  assign ext.rsp_rdata = mem.rsp_rdata;

  always_comb begin
    case (owner)
      OWN_LSU: mem.rsp_ready = lsu.rsp_ready;
      OWN_EXT: mem.rsp_ready = ext.rsp_ready;
      default: mem.rsp_ready = 1'b0;
    endcase
  end

endmodule

//--- source/dtcm_pkg.sv
// DTCM controller types
// Response ownership for the arbiter and the SRAM controller FSM states

package dtcm_pkg;

  // Which requester the pending response belongs to
  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,
    OWN_LSU  = 2'd1,
    OWN_EXT  = 2'd2
  } rsp_owner_e;

  // SRAM controller FSM
  // IDLE accepts one command, RSP holds the response until taken
  typedef enum logic {
    SRAM_IDLE = 1'b0,
    SRAM_RSP  = 1'b1
  } sram_state_e;

endpackage

//--- source/dtcm_sram_ctrl.sv
// DTCM SRAM controller
// Turns ICB commands into single-port SRAM accesses, flags misaligned addresses

`timescale 1ns/100ps

`include "cpu_params.svh"

module dtcm_sram_ctrl (
  input  logic               clk,
  input  logic               reset,
  icb_if.slave               icb,
  output logic               ram_cs,
  output logic               ram_we,
  output icb_pkg::ram_addr_t ram_addr,
  output icb_pkg::icb_mask_t ram_wem,
  output icb_pkg::icb_data_t ram_din,
  input  icb_pkg::icb_data_t ram_dout
);
  import icb_pkg::*;
  import dtcm_pkg::*;

  sram_state_e state;
  logic        live;       // out of reset, may take commands
  logic        misaligned;
  logic        cmd_fire;
  logic        rsp_fire;
  logic        rsp_read;
  logic        rsp_fresh;  // first response cycle, SRAM output is current
  logic        rsp_err_q;
  icb_data_t   rdata_hold;

  assign misaligned    = |icb.cmd_addr[1:0];
  assign icb.cmd_ready = live & (state == SRAM_IDLE);
  assign cmd_fire      = icb.cmd_valid & icb.cmd_ready;
  assign rsp_fire      = icb.rsp_valid & icb.rsp_ready;

  //////////////////////////////////////////////////
  // SRAM side, misaligned commands never reach the macro

  assign ram_cs   = cmd_fire & ~misaligned;
  assign ram_we   = icb.cmd_kind == ICB_WRITE;
  assign ram_addr = icb.cmd_addr[`DTCM_RAM_AW+1:2];
  assign ram_wem  = ram_we ? icb.cmd_wmask : '0;
  assign ram_din  = icb.cmd_wdata;

  //////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk) begin
    if (reset) begin
      live      <= 1'b0;
      state     <= SRAM_IDLE;
      rsp_fresh <= 1'b0;
      rsp_read  <= 1'b0;
      rsp_err_q <= 1'b0;
    end else begin
      live      <= 1'b1;
      rsp_fresh <= cmd_fire;
      if (cmd_fire) begin
        rsp_read  <= (icb.cmd_kind == ICB_READ) & ~misaligned;
        rsp_err_q <= misaligned;
      end
      case (state)
        SRAM_IDLE: if (cmd_fire) state <= SRAM_RSP;
        SRAM_RSP:  if (rsp_fire) state <= SRAM_IDLE;
        default:   state <= SRAM_IDLE;
      endcase
    end
  end

  // SRAM output is only good for one cycle, keep a copy for stalls
  always_ff @(posedge clk) begin
    if (rsp_fresh) begin
      rdata_hold <= ram_dout;
    end
  end

  //////////////////////////////////////////////////
  // Response

  assign icb.rsp_valid = state == SRAM_RSP;
  assign icb.rsp_err   = rsp_err_q;
  // Writes and errors return zero
  assign icb.rsp_rdata = !rsp_read ? '0 : (rsp_fresh ? ram_dout : rdata_hold);

endmodule

//--- source/icb_if.sv
// ICB link with separate command and response channels
// Each channel uses a valid/ready handshake

`timescale 1ns/100ps

interface icb_if;
  import icb_pkg::*;

  // Command channel
  logic      cmd_valid;
  logic      cmd_ready;
  icb_addr_t cmd_addr;
  icb_kind_e cmd_kind;
  icb_data_t cmd_wdata;
  icb_mask_t cmd_wmask;

  // Response channel
  logic      rsp_valid;
  logic      rsp_ready;
  logic      rsp_err;
  icb_data_t rsp_rdata;

  modport master (
    output cmd_valid, cmd_addr, cmd_kind, cmd_wdata, cmd_wmask,
    input  cmd_ready,
    input  rsp_valid, rsp_err, rsp_rdata,
    output rsp_ready
  );

  modport slave (
    input  cmd_valid, cmd_addr, cmd_kind, cmd_wdata, cmd_wmask,
    output cmd_ready,
    output rsp_valid, rsp_err, rsp_rdata,
    input  rsp_ready
  );

endinterface

//--- source/icb_pkg.sv
// ICB bus types
// Payload widths and the command kind carried on the read bit

package icb_pkg;

`include "cpu_params.svh"

  // One bus word
  typedef logic [`CPU_XLEN-1:0] icb_data_t;

  // Byte lane enables, one per byte of a word
  typedef logic [`CPU_XLEN/8-1:0] icb_mask_t;

  // Byte address into the DTCM
  typedef logic [`DTCM_ADDR_WIDTH-1:0] icb_addr_t;

  // Word address on the SRAM side
  typedef logic [`DTCM_RAM_AW-1:0] ram_addr_t;

  // Command kind, encoded the same way as the ICB read bit
  typedef enum logic {
    ICB_WRITE = 1'b0,
    ICB_READ  = 1'b1
  } icb_kind_e;

endpackage

//--- tb/cpu_top_asserts.sv
// ICB handshake and reset rules on the CPU top
// Bound into cpu_top

`timescale 1ns/100ps

module cpu_top_asserts (
  input logic        clk,
  input logic        reset,
  input logic        dtcm_reset,
  input logic        lsu_cmd_valid,
  input logic        lsu_cmd_ready,
  input logic        lsu_cmd_read,
  input logic [15:0] lsu_cmd_addr,
  input logic [31:0] lsu_cmd_wdata,
  input logic [3:0]  lsu_cmd_wmask,
  input logic        lsu_rsp_valid,
  input logic        ext_cmd_valid,
  input logic        ext_cmd_ready,
  input logic        ext_cmd_read,
  input logic [15:0] ext_cmd_addr,
  input logic [31:0] ext_cmd_wdata,
  input logic [3:0]  ext_cmd_wmask,
  input logic        ext_rsp_valid,
  input logic        ram_cs
);

  // Waiting command keeps its payload
  a_lsu_stable: assert property (@(posedge clk) disable iff (reset)
    (lsu_cmd_valid && !lsu_cmd_ready) |=> (lsu_cmd_valid && $stable(lsu_cmd_addr)
    && $stable(lsu_cmd_read) && $stable(lsu_cmd_wdata) && $stable(lsu_cmd_wmask)))
    else $error("LSU command changed while waiting for ready");

  a_ext_stable: assert property (@(posedge clk) disable iff (reset)
    (ext_cmd_valid && !ext_cmd_ready) |=> (ext_cmd_valid && $stable(ext_cmd_addr)
    && $stable(ext_cmd_read) && $stable(ext_cmd_wdata) && $stable(ext_cmd_wmask)))
    else $error("External command changed while waiting for ready");

  a_no_rsp_in_reset: assert property (@(posedge clk) disable iff (reset)
    dtcm_reset |-> (!lsu_rsp_valid && !ext_rsp_valid))
    else $error("Response valid while the DTCM is in reset");

  // Chip select only with an aligned command handshake on one of the ports
  a_cs_aligned: assert property (@(posedge clk) disable iff (reset)
    ram_cs |-> ((ext_cmd_valid && ext_cmd_ready && ext_cmd_addr[1:0] == 2'b00)
    || (lsu_cmd_valid && lsu_cmd_ready && lsu_cmd_addr[1:0] == 2'b00)))
    else $error("SRAM selected without an aligned command handshake");

endmodule

bind cpu_top cpu_top_asserts u_asserts (
  .clk(clk), .reset(reset), .dtcm_reset(dtcm_reset),
  .lsu_cmd_valid(lsu_cmd_valid), .lsu_cmd_ready(lsu_cmd_ready), .lsu_cmd_read(lsu_cmd_read),
  .lsu_cmd_addr(lsu_cmd_addr), .lsu_cmd_wdata(lsu_cmd_wdata), .lsu_cmd_wmask(lsu_cmd_wmask),
  .lsu_rsp_valid(lsu_rsp_valid),
  .ext_cmd_valid(ext_cmd_valid), .ext_cmd_ready(ext_cmd_ready), .ext_cmd_read(ext_cmd_read),
  .ext_cmd_addr(ext_cmd_addr), .ext_cmd_wdata(ext_cmd_wdata), .ext_cmd_wmask(ext_cmd_wmask),
  .ext_rsp_valid(ext_rsp_valid), .ram_cs(ram_cs)
);

//--- tb/tb_cpu_top.sv
// Testbench for the CPU integration top
// Reset release, IRQ sync latency and DTCM traffic checked against a shadow memory

`timescale 1ns/100ps

`include "cpu_params.svh"

module tb_cpu_top;
  import icb_pkg::*;

  localparam int TIMEOUT = 200;

  logic clk, reset;
  logic [3:0] irq_a;
  logic [3:0] irq_r;
  logic [1:0] cmd_valid, cmd_read, rsp_ready;
  icb_addr_t  cmd_addr [2];
  icb_data_t  cmd_wdata [2];
  icb_mask_t  cmd_wmask [2];
  logic lsu_cmd_ready, ext_cmd_ready, lsu_rsp_valid, ext_rsp_valid, lsu_rsp_err, ext_rsp_err;
  icb_data_t lsu_rsp_rdata, ext_rsp_rdata, ram_din, ram_dout;
  logic ram_cs, ram_we;
  ram_addr_t ram_addr;
  icb_mask_t ram_wem;

  icb_data_t sram [1 << `DTCM_RAM_AW];
  icb_data_t shadow [1 << `DTCM_RAM_AW];
  icb_data_t exp_data_q [2][$];
  logic      exp_err_q [2][$];
  int        done_order [$];
  logic [1:0] pending;
  icb_data_t held_data [2];
  logic [31:0] lfsr_state = 32'ha87b;
  logic gaps_on = 1'b0;
  int err_cnt = 0;
  int test_cnt = 0;

  cpu_top dut (
    .clk(clk), .reset(reset),
    .dbg_irq_a(irq_a[3]), .ext_irq_a(irq_a[2]), .sft_irq_a(irq_a[1]), .tmr_irq_a(irq_a[0]),
    .dbg_irq_r(irq_r[3]), .ext_irq_r(irq_r[2]), .sft_irq_r(irq_r[1]), .tmr_irq_r(irq_r[0]),
    .lsu_cmd_valid(cmd_valid[0]), .lsu_cmd_ready(lsu_cmd_ready), .lsu_cmd_addr(cmd_addr[0]),
    .lsu_cmd_read(cmd_read[0]), .lsu_cmd_wdata(cmd_wdata[0]), .lsu_cmd_wmask(cmd_wmask[0]),
    .lsu_rsp_valid(lsu_rsp_valid), .lsu_rsp_ready(rsp_ready[0]), .lsu_rsp_err(lsu_rsp_err),
    .lsu_rsp_rdata(lsu_rsp_rdata),
    .ext_cmd_valid(cmd_valid[1]), .ext_cmd_ready(ext_cmd_ready), .ext_cmd_addr(cmd_addr[1]),
    .ext_cmd_read(cmd_read[1]), .ext_cmd_wdata(cmd_wdata[1]), .ext_cmd_wmask(cmd_wmask[1]),
    .ext_rsp_valid(ext_rsp_valid), .ext_rsp_ready(rsp_ready[1]), .ext_rsp_err(ext_rsp_err),
    .ext_rsp_rdata(ext_rsp_rdata),
    .ram_cs(ram_cs), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wem(ram_wem),
    .ram_din(ram_din), .ram_dout(ram_dout)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return val;
  endfunction

  // Reference model of a DTCM access that updates the shadow on aligned writes
  function automatic icb_data_t ref_access(input icb_addr_t addr, input logic read,
                                           input icb_data_t wdata, input icb_mask_t wmask);
    ram_addr_t idx;
    idx = addr[`DTCM_RAM_AW+1:2];
    if (addr[1:0] != 2'b00) return '0;
    if (read) return shadow[idx];
    for (int b = 0; b < 4; b++) begin
      if (wmask[b]) shadow[idx][b*8 +: 8] = wdata[b*8 +: 8];
    end
    return '0;
  endfunction

  task automatic check_data(input string name, input icb_data_t exp, input icb_data_t act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s err expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Result: FAILED");
    $finish;
  endtask

  // One-cycle SRAM with byte-masked writes
  always @(posedge clk) begin
    if (ram_cs && ram_we) begin
      for (int b = 0; b < 4; b++) begin
        if (ram_wem[b]) sram[ram_addr][b*8 +: 8] <= ram_din[b*8 +: 8];
      end
    end else if (ram_cs) begin
      ram_dout <= sram[ram_addr];
    end
  end

  // Ready gaps change only after the rising edge
  always @(posedge clk) begin
    #2 rsp_ready <= gaps_on ? 2'(rand_bits(2)) : 2'b11;
  end

  task automatic take_rsp(input int p, input logic v, input logic r, input logic e,
                          input icb_data_t d);
    if (pending[p] && !v) begin
      $display("Port %0d dropped its response before the handshake", p);
      err_cnt++;
    end
    if (pending[p]) check_data("rsp_hold", held_data[p], d);
    pending[p] = 1'b0;
    if (v && r) begin
      if (exp_data_q[p].size() == 0) begin
        $display("Port %0d returned a response with no command outstanding", p);
        err_cnt++;
      end else begin
        check_data("rsp_data", exp_data_q[p].pop_front(), d);
        check_err("rsp_err", exp_err_q[p].pop_front(), e);
        done_order.push_back(p);
      end
    end else if (v) begin
      pending[p] = 1'b1;
      held_data[p] = d;
    end
  endtask

  // Response compare at the falling edge where the handshake inputs are stable
  always @(negedge clk) begin
    if (!reset) begin
      take_rsp(0, lsu_rsp_valid, rsp_ready[0], lsu_rsp_err, lsu_rsp_rdata);
      take_rsp(1, ext_rsp_valid, rsp_ready[1], ext_rsp_err, ext_rsp_rdata);
    end
  end

  task automatic issue_cmd(input int p, input icb_addr_t addr, input logic read,
                           input icb_data_t wdata, input icb_mask_t wmask);
    int t;
    t = 0;
    @(posedge clk);
    #2;
    cmd_valid[p] = 1'b1;
    cmd_addr[p] = addr;
    cmd_read[p] = read;
    cmd_wdata[p] = wdata;
    cmd_wmask[p] = wmask;
    do begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) timeout_fail("cmd_ready");
    end while (!(p == 0 ? lsu_cmd_ready : ext_cmd_ready));
    exp_data_q[p].push_back(ref_access(addr, read, wdata, wmask));
    exp_err_q[p].push_back(addr[1:0] != 2'b00);
    @(posedge clk);
    #2 cmd_valid[p] = 1'b0;
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (exp_data_q[0].size() != 0 || exp_data_q[1].size() != 0) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) timeout_fail("outstanding responses");
    end
  endtask

  task automatic random_op(input int p, input logic bad_align);
    icb_addr_t addr;
    addr = icb_addr_t'(rand_bits(6) << 2);
    if (bad_align) addr[1:0] = 2'(1 + rand_bits(2) % 3);
    issue_cmd(p, addr, rand_bits(1) == 1, rand_bits(32), icb_mask_t'(rand_bits(4)));
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %s: %s", name, err_cnt == errs_before ? "ok" : "errors");
  endtask

  initial begin
    int e, cnt, order_first;
    reset = 1'b1;
    irq_a = '0;
    cmd_valid = '0;
    cmd_read = '0;
    rsp_ready = 2'b11;
    pending = '0;
    ram_dout = '0;
    for (int i = 0; i < 2; i++) begin
      cmd_addr[i] = '0;
      cmd_wdata[i] = '0;
      cmd_wmask[i] = '0;
    end
    for (int i = 0; i < (1 << `DTCM_RAM_AW); i++) begin
      sram[i] = i * 32'h9e3779b1 + 32'h1234;
      shadow[i] = sram[i];
    end
    repeat (8) @(posedge clk);
    #2 reset = 1'b0;

    // Memory domain release
    e = err_cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      #1;
      if (!lsu_cmd_ready) cnt++;
      if (cnt > TIMEOUT) timeout_fail("cmd_ready after reset");
    end while (!lsu_cmd_ready);
    check_count("reset_release", `DTCM_RST_CYCLES, cnt);
    check_count("reset_release_ext", 1, int'(ext_cmd_ready));
    end_test("reset_release", e);

    // Interrupt sync latency with one line toggled at a time
    e = err_cnt;
    for (int k = 0; k < 8; k++) begin
      @(posedge clk);
      #2 irq_a[k % 4] = ~irq_a[k % 4];
      cnt = 0;
      do begin
        @(posedge clk);
        #1 cnt++;
        if (cnt > TIMEOUT) timeout_fail("interrupt output");
      end while (irq_r !== irq_a);
      check_count("irq_sync", `IRQ_SYNC_STAGES, cnt);
    end
    end_test("irq_sync", e);

    e = err_cnt;
    for (int k = 0; k < 40; k++) random_op(0, 1'b0);
    drain();
    end_test("lsu_random", e);

    // Both ports in the same cycle
    e = err_cnt;
    for (int k = 0; k < 6; k++) begin
      done_order.delete();
      fork
        random_op(1, 1'b0);
        random_op(0, 1'b0);
      join
      drain();
      order_first = done_order[0];
      check_count("ext_first", 1, order_first);
    end
    end_test("both_ports", e);

    e = err_cnt;
    gaps_on = 1'b1;
    for (int k = 0; k < 40; k++) random_op(k % 2, 1'b0);
    drain();
    gaps_on = 1'b0;
    end_test("ready_gaps", e);

    // Misaligned accesses followed by a full SRAM compare against the shadow
    e = err_cnt;
    for (int k = 0; k < 16; k++) random_op(k % 2, 1'b1);
    drain();
    for (int i = 0; i < (1 << `DTCM_RAM_AW); i++) check_data("sram_intact", shadow[i], sram[i]);
    end_test("misaligned", e);

    $display("tests %0d errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Run limit
  initial begin
    #2000000;
    timeout_fail("the end of the run");
  end

endmodule
